/* rtl/i2c_cmd_issue.sv */
/*
 * output registers toward the I2C master
 * accepts every op_valid; the sequencer only sends one while idle is high
 * set_addr arms start and address, which ride on the next write command
 * a stop drops any armed start
 */
module i2c_cmd_issue
    import i2c_init_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  op_valid,
    input  issue_op_t             op_kind,
    input  logic [dev_addr_w-1:0] op_addr,
    input  logic [byte_w-1:0]     op_data,
    output logic                  idle,
    output logic [dev_addr_w-1:0] cmd_address,
    output logic                  cmd_start,
    output logic                  cmd_write,
    output logic                  cmd_stop,
    output logic                  cmd_valid,
    input  logic                  cmd_ready,
    output logic [byte_w-1:0]     data_out,
    output logic                  data_out_valid,
    input  logic                  data_out_ready
);

    logic start_pending;

    // nothing waiting on either channel
    assign idle = !cmd_valid && !data_out_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_valid      <= 1'b0;
            cmd_start      <= 1'b0;
            cmd_write      <= 1'b0;
            cmd_stop       <= 1'b0;
            data_out_valid <= 1'b0;
            start_pending  <= 1'b0;
        end else begin
            // handshakes retire the current transfer
            if (cmd_valid && cmd_ready) begin
                cmd_valid <= 1'b0;
                cmd_start <= 1'b0;
                cmd_write <= 1'b0;
                cmd_stop  <= 1'b0;
            end
            if (data_out_valid && data_out_ready) begin
                data_out_valid <= 1'b0;
            end

            if (op_valid) begin
                case (op_kind)
                    set_addr: begin
                        start_pending <= 1'b1;
                    end
                    write_byte: begin
                        // command and data leave together
                        cmd_valid      <= 1'b1;
                        cmd_start      <= start_pending;
                        cmd_write      <= 1'b1;
                        cmd_stop       <= 1'b0;
                        data_out_valid <= 1'b1;
                        start_pending  <= 1'b0;
                    end
                    send_stop: begin
                        cmd_valid     <= 1'b1;
                        cmd_start     <= 1'b0;
                        cmd_write     <= 1'b0;
                        cmd_stop      <= 1'b1;
                        start_pending <= 1'b0;
                    end
                    default: begin
                        start_pending <= start_pending;
                    end
                endcase
            end
        end
    end

    // payload, only loaded while idle so it holds through back-pressure
    always_ff @(posedge clk) begin
        if (op_valid && op_kind == set_addr) begin
            cmd_address <= op_addr;
        end
        if (op_valid && op_kind == write_byte) begin
            data_out <= op_data;
        end
    end

    a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> $stable({cmd_address, cmd_start, cmd_write, cmd_stop}));

    a_data_hold: assert property (@(posedge clk) disable iff (rst)
        data_out_valid && !data_out_ready |=> $stable(data_out));

endmodule

/* rtl/i2c_init.sv */
/*
 * boot-time I2C init sequencer
 * fetch -> sequencer -> issue, commands go to an external I2C master
 * read, write-multiple and data-last are left to the master
 * start-to-first-command latency depends on table content and ready
 */
module i2c_init
    import i2c_init_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    output logic [dev_addr_w-1:0] cmd_address,
    output logic                  cmd_start,
    output logic                  cmd_write,
    output logic                  cmd_stop,
    output logic                  cmd_valid,
    input  logic                  cmd_ready,
    output logic [byte_w-1:0]     data_out,
    output logic                  data_out_valid,
    input  logic                  data_out_ready,
    output logic                  busy
);

    // fetch <-> sequencer
    logic [table_aw-1:0]     rd_index;
    logic [table_word_w-1:0] word_q;

    // sequencer <-> issue
    logic                  idle;
    logic                  op_valid;
    issue_op_t             op_kind;
    logic [dev_addr_w-1:0] op_addr;
    logic [byte_w-1:0]     op_data;

    init_table_fetch fetch_i (
        .clk      (clk),
        .rd_index (rd_index),
        .word_q   (word_q)
    );

    init_sequencer seq_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .word_q   (word_q),
        .idle     (idle),
        .rd_index (rd_index),
        .op_valid (op_valid),
        .op_kind  (op_kind),
        .op_addr  (op_addr),
        .op_data  (op_data),
        .busy     (busy)
    );

    i2c_cmd_issue issue_i (
        .clk            (clk),
        .rst            (rst),
        .op_valid       (op_valid),
        .op_kind        (op_kind),
        .op_addr        (op_addr),
        .op_data        (op_data),
        .idle           (idle),
        .cmd_address    (cmd_address),
        .cmd_start      (cmd_start),
        .cmd_write      (cmd_write),
        .cmd_stop       (cmd_stop),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

endmodule

/* rtl/i2c_init_pkg.sv */
/*
 * shared widths and encodings for the I2C init sequencer
 * table words are 9 bits; control words carry a leading 00
 * 01aaaaaaa starts a write to address a, 1dddddddd writes data byte d
 * table_len must stay below 2**table_aw so every index is addressable
 */
package i2c_init_pkg;

    // table geometry
    localparam int table_word_w = 9;
    localparam int table_aw     = 6;
    localparam int table_len    = 40;

    // I2C payload widths
    localparam int dev_addr_w = 7;
    localparam int byte_w     = 8;

    // control word opcodes, full 9-bit match
    localparam logic [table_word_w-1:0] op_end        = 9'b000000000;
    localparam logic [table_word_w-1:0] op_exit_mode  = 9'b000000001;
    localparam logic [table_word_w-1:0] op_cur_addr   = 9'b000000011;
    localparam logic [table_word_w-1:0] op_addr_block = 9'b000001000;
    localparam logic [table_word_w-1:0] op_data_block = 9'b000001001;
    localparam logic [table_word_w-1:0] op_send_stop  = 9'b001000001;

    // sequencer modes
    // find_addr_block scans forward after a data block word
    // next_addr pulls one device address out of the address block
    // replay walks the data block for the current address
    typedef enum logic [2:0] {
        seq_idle,
        seq_run,
        seq_find_addr_block,
        seq_next_addr,
        seq_replay
    } seq_state_t;

    // operations handed from the sequencer to the issue stage
    // set_addr only arms start and address for the next write
    typedef enum logic [1:0] {
        set_addr,
        write_byte,
        send_stop
    } issue_op_t;

endpackage

/* rtl/init_sequencer.sv */
/*
 * mode FSM walking the init table
 * word_q always belongs to index_reg since rd_index is the next index
 * a run starts on a rising start edge seen in idle; start must drop before a rerun
 * nothing advances while the issue stage holds a pending transfer
 * unknown words are skipped, the end word closes with a stop and returns to idle
 */
module init_sequencer
    import i2c_init_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [table_word_w-1:0] word_q,
    input  logic                    idle,
    output logic [table_aw-1:0]     rd_index,
    output logic                    op_valid,
    output issue_op_t               op_kind,
    output logic [dev_addr_w-1:0]   op_addr,
    output logic [byte_w-1:0]       op_data,
    output logic                    busy
);

    seq_state_t state_reg, state_next;

    logic [table_aw-1:0] index_reg, index_next;
    logic [table_aw-1:0] data_ptr_reg, data_ptr_next;
    logic [table_aw-1:0] addr_ptr_reg, addr_ptr_next;

    logic [dev_addr_w-1:0] cur_addr_reg, cur_addr_next;

    logic start_flag_reg, start_flag_next;
    logic busy_reg;

    // word classes
    logic is_data_word;
    logic is_addr_word;

    assign is_data_word = word_q[table_word_w-1];
    assign is_addr_word = (word_q[table_word_w-1 -: 2] == 2'b01);

    // next word goes straight to the ROM
    assign rd_index = index_next;
    assign busy     = busy_reg;

    always_comb begin
        state_next      = state_reg;
        index_next      = index_reg;
        data_ptr_next   = data_ptr_reg;
        addr_ptr_next   = addr_ptr_reg;
        cur_addr_next   = cur_addr_reg;
        start_flag_next = start_flag_reg;

        op_valid = 1'b0;
        op_kind  = write_byte;
        op_addr  = word_q[dev_addr_w-1:0];
        op_data  = word_q[byte_w-1:0];

        if (state_reg == seq_idle) begin
            // rising edge only, flag blocks a held start
            if (start && !start_flag_reg) begin
                index_next      = '0;
                start_flag_next = 1'b1;
                state_next      = seq_run;
            end
        end else if (idle) begin
            // default step to the following word
            index_next = index_reg + 1'b1;

            if (word_q == op_end) begin
                // final stop toward the master
                op_valid   = 1'b1;
                op_kind    = send_stop;
                index_next = index_reg;
                state_next = seq_idle;
            end else if (word_q == op_data_block) begin
                // remember block start, then look for its addresses
                data_ptr_next = index_reg + 1'b1;
                state_next    = seq_find_addr_block;
            end else if (word_q == op_exit_mode && state_reg != seq_run) begin
                state_next = seq_run;
            end else begin
                case (state_reg)
                    seq_run, seq_replay: begin
                        if (is_data_word) begin
                            op_valid = 1'b1;
                            op_kind  = write_byte;
                        end else if (is_addr_word) begin
                            op_valid = 1'b1;
                            op_kind  = set_addr;
                        end else if (word_q == op_send_stop) begin
                            op_valid = 1'b1;
                            op_kind  = send_stop;
                        end else if (state_reg == seq_replay && word_q == op_cur_addr) begin
                            // substitute the device from the address block
                            op_valid = 1'b1;
                            op_kind  = set_addr;
                            op_addr  = cur_addr_reg;
                        end else if (state_reg == seq_replay && word_q == op_addr_block) begin
                            // data block done, fetch the next address
                            index_next = addr_ptr_reg;
                            state_next = seq_next_addr;
                        end
                    end
                    seq_find_addr_block: begin
                        if (word_q == op_addr_block) begin
                            addr_ptr_next = index_reg + 1'b1;
                            state_next    = seq_next_addr;
                        end
                    end
                    seq_next_addr: begin
                        if (is_addr_word) begin
                            // latch device, jump back to the data block
                            cur_addr_next = word_q[dev_addr_w-1:0];
                            addr_ptr_next = index_reg + 1'b1;
                            index_next    = data_ptr_reg;
                            state_next    = seq_replay;
                        end
                    end
                    default: begin
                        state_next = seq_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg      <= seq_idle;
            index_reg      <= '0;
            start_flag_reg <= 1'b0;
            busy_reg       <= 1'b0;
        end else begin
            state_reg      <= state_next;
            index_reg      <= index_next;
            // clears once start is low
            start_flag_reg <= start & start_flag_next;
            busy_reg       <= (state_reg != seq_idle);
        end
    end

    // block pointers and current device address
    always_ff @(posedge clk) begin
        data_ptr_reg <= data_ptr_next;
        addr_ptr_reg <= addr_ptr_next;
        cur_addr_reg <= cur_addr_next;
    end

    // a transfer loaded into the issue stage freezes the walk on the next cycle
    a_freeze_after_load: assert property (@(posedge clk) disable iff (rst)
        op_valid && op_kind != set_addr |=> !op_valid);

    // replay never leaves the data block ahead of the current address entry
    a_replay_in_block: assert property (@(posedge clk) disable iff (rst)
        state_reg == seq_replay |-> index_reg >= data_ptr_reg && index_reg < addr_ptr_reg);

endmodule

/* rtl/init_table.svh */
/*
 * init command table, one word per ROM entry
 * included inside the initial block of the fetch stage, which owns rom[]
 * entries past the end word keep the fill value op_end
 */
`ifndef INIT_TABLE_SVH
`define INIT_TABLE_SVH

// device 0x76, register 0x49 <- 0xc0
rom[0]  = {2'b01, 7'h76};
rom[1]  = {1'b1, 8'h49};
rom[2]  = {1'b1, 8'hc0};
rom[3]  = op_send_stop;
// device 0x76, register 0x21 <- 0x09
rom[4]  = {2'b01, 7'h76};
rom[5]  = {1'b1, 8'h21};
rom[6]  = {1'b1, 8'h09};
rom[7]  = op_send_stop;
// shared block, replayed per address below
rom[8]  = op_data_block;
rom[9]  = op_cur_addr;
rom[10] = {1'b1, 8'h10};
rom[11] = {1'b1, 8'h04};
rom[12] = op_send_stop;
rom[13] = op_addr_block;
rom[14] = {2'b01, 7'h50};
rom[15] = {2'b01, 7'h51};
rom[16] = {2'b01, 7'h52};
// back to plain sequential commands
rom[17] = op_exit_mode;
// not an opcode, sequencer skips it
rom[18] = {2'b00, 7'h7e};
rom[19] = {2'b01, 7'h3c};
rom[20] = {1'b1, 8'h5a};
rom[21] = op_send_stop;
rom[22] = op_end;

`endif

/* rtl/init_table_fetch.sv */
/*
 * table ROM with one registered read per cycle
 * word_q is the word at the rd_index of the previous cycle
 * contents come from init_table.svh, unused entries read as op_end
 * rd_index must stay below table_len
 */
module init_table_fetch
    import i2c_init_pkg::*;
(
    input  logic                    clk,
    input  logic [table_aw-1:0]     rd_index,
    output logic [table_word_w-1:0] word_q
);

    logic [table_word_w-1:0] rom [table_len];

    // fill first so the tail of the table ends the run
    initial begin
        for (int i = 0; i < table_len; i++) begin
            rom[i] = op_end;
        end
        `include "init_table.svh"
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        word_q <= rom[rd_index];
    end

    // sequencer pointers never leave the table
    a_index_in_range: assert property (@(posedge clk) rd_index < table_aw'(table_len));

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module i2c_init_tb -Mdir obj_dir -f src.f

./obj_dir/Vi2c_init_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

/* src.f */
+incdir+rtl
rtl/i2c_init_pkg.sv
rtl/init_table_fetch.sv
rtl/init_sequencer.sv
rtl/i2c_cmd_issue.sv
rtl/i2c_init.sv
tb/i2c_init_tb.sv

/* tb/i2c_init_tb.sv */
/*
 * testbench for the i2c_init sequencer
 * expected handshake stream, run count and stall rate come from tb/init_stimulus.txt
 * run from the project root so the stimulus path resolves
 * commands and data are checked in handshake order, never by cycle
 */
module i2c_init_tb
    import i2c_init_pkg::*;
();

    logic clk = 1'b0;
    logic rst;
    logic start;
    logic cmd_ready;
    logic data_out_ready;
    logic [dev_addr_w-1:0] cmd_address;
    logic cmd_start;
    logic cmd_write;
    logic cmd_stop;
    logic cmd_valid;
    logic [byte_w-1:0] data_out;
    logic data_out_valid;
    logic busy;

    // expected stream for one run, flags are {start, write, stop}
    logic [2:0] exp_flags [$];
    logic [dev_addr_w-1:0] exp_addr [$];
    logic [byte_w-1:0] exp_data [$];
    int n_cmds = 0;
    int n_data = 0;
    int runs = 0;
    int stall_pct = 0;

    int cmd_seen = 0;
    int data_seen = 0;
    int cycles = 0;
    int cycle_limit = 0;
    logic [31:0] rng_state = 32'd25;
    logic monitor_on = 1'b0;

    // payload snapshot of a stalled cycle
    logic held_cmd = 1'b0;
    logic held_data = 1'b0;
    logic [dev_addr_w-1:0] held_addr;
    logic [2:0] held_flags;
    logic [byte_w-1:0] held_byte;

    i2c_init dut_i (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .cmd_address    (cmd_address),
        .cmd_start      (cmd_start),
        .cmd_write      (cmd_write),
        .cmd_stop       (cmd_stop),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready),
        .busy           (busy)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR: time %0t signal %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // comment lines start with #, first data line is the run header
    task automatic read_stimulus();
        int fd;
        int got;
        int s, w, p, a, d;
        bit have_header;
        string line;
        fd = $fopen("tb/init_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/init_stimulus.txt");
            stop_with_failure();
        end
        have_header = 1'b0;
        while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 2 && line[0] != "#") begin
                if (!have_header) begin
                    got = $sscanf(line, "%d %d", runs, stall_pct);
                    have_header = 1'b1;
                end else if ($sscanf(line, "%d %d %d %h %h", s, w, p, a, d) == 5) begin
                    exp_flags.push_back({s[0], w[0], p[0]});
                    exp_addr.push_back(a[dev_addr_w-1:0]);
                    if (w != 0) exp_data.push_back(d[byte_w-1:0]);
                end
            end
        end
        $fclose(fd);
        n_cmds = exp_flags.size();
        n_data = exp_data.size();
        if (n_cmds == 0 || runs == 0) begin
            $display("stimulus file holds no commands or no run count");
            stop_with_failure();
        end
    endtask

    // random back-pressure on both channels
    always @(posedge clk) begin
        #1;
        rng_state = xorshift32(rng_state);
        cmd_ready = int'(rng_state % 100) >= stall_pct;
        rng_state = xorshift32(rng_state);
        data_out_ready = int'(rng_state % 100) >= stall_pct;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the runs did not complete", cycles);
            stop_with_failure();
        end
    end

    // handshake monitor, sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        int idx;
        if (monitor_on) begin
            if (held_cmd) begin
                check_value("cmd_valid", 1, cmd_valid);
                check_value("cmd_address", held_addr, cmd_address);
                check_value("cmd_flags", held_flags, {cmd_start, cmd_write, cmd_stop});
            end
            if (held_data) begin
                check_value("data_out_valid", 1, data_out_valid);
                check_value("data_out", held_byte, data_out);
            end
            if (cmd_valid && cmd_ready) begin
                if (cmd_seen >= runs * n_cmds) begin
                    $display("extra command handshake beyond the expected stream");
                    stop_with_failure();
                end
                idx = cmd_seen % n_cmds;
                check_value("cmd_start", exp_flags[idx][2], cmd_start);
                check_value("cmd_write", exp_flags[idx][1], cmd_write);
                check_value("cmd_stop", exp_flags[idx][0], cmd_stop);
                check_value("cmd_address", exp_addr[idx], cmd_address);
                // last stop of a run may land after busy has dropped
                if (idx != n_cmds - 1) check_value("busy", 1, busy);
                cmd_seen = cmd_seen + 1;
            end
            if (data_out_valid && data_out_ready) begin
                if (data_seen >= runs * n_data) begin
                    $display("extra data handshake beyond the expected stream");
                    stop_with_failure();
                end
                check_value("data_out", exp_data[data_seen % n_data], data_out);
                data_seen = data_seen + 1;
            end
            held_cmd = cmd_valid && !cmd_ready;
            held_data = data_out_valid && !data_out_ready;
            held_addr = cmd_address;
            held_flags = {cmd_start, cmd_write, cmd_stop};
            held_byte = data_out;
        end
    end

    // outputs quiet for n cycles
    task automatic expect_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            check_value("cmd_valid", 0, cmd_valid);
            check_value("data_out_valid", 0, data_out_valid);
            check_value("busy", 0, busy);
        end
    endtask

    // one start edge, wait for the whole stream, then hold start high
    task automatic run_table(input int r);
        @(posedge clk);
        #1;
        start = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("busy", 1, busy);
        while (cmd_seen < (r + 1) * n_cmds || data_seen < (r + 1) * n_data) begin
            @(posedge clk);
        end
        // held start must not retrigger
        expect_quiet(20);
        @(posedge clk);
        #1;
        start = 1'b0;
        expect_quiet(3);
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        cmd_ready = 1'b0;
        data_out_ready = 1'b0;
        read_stimulus();
        cycle_limit = n_cmds * runs * 16 + 200;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        monitor_on = 1'b1;
        expect_quiet(10);
        for (int r = 0; r < runs; r++) begin
            run_table(r);
        end
        if (cmd_seen != runs * n_cmds || data_seen != runs * n_data) begin
            $display("handshake count differs from the stream, %0d commands %0d bytes",
                     cmd_seen, data_seen);
            stop_with_failure();
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* tb/init_stimulus.txt */
# run count, ready stall percent (0..99)
2 40
# one line per command handshake of a single table run
# start write stop address(hex) data(hex, 00 when write is 0)
# device 0x76, two register writes
1 1 0 76 49
0 1 0 76 c0
0 0 1 76 00
1 1 0 76 21
0 1 0 76 09
0 0 1 76 00
# data block replayed for 0x50, 0x51, 0x52
1 1 0 50 10
0 1 0 50 04
0 0 1 50 00
1 1 0 51 10
0 1 0 51 04
0 0 1 51 00
1 1 0 52 10
0 1 0 52 04
0 0 1 52 00
# back in single-device mode, unknown word gives nothing
1 1 0 3c 5a
0 0 1 3c 00
# end word closes with a bare stop
0 0 1 3c 00
